// ==== verilog.f ====
src/qenc_pkg.sv
src/qenc_ctrl_if.sv
src/qenc_input_sync.sv
src/qenc_position_core.sv
src/qenc_apb_regs.sv
src/qenc_top.sv
dv/qenc_asserts.sv
dv/qenc_tb.sv

// ==== dv/qenc_tb.sv ====
`timescale 1ns/1ps

module qenc_tb;
    import qenc_pkg::*;

    typedef enum int {
        OP_WRITE, OP_READ, OP_READ_ERR, OP_UP, OP_DOWN, OP_INDEX, OP_WAIT, OP_PINS
    } op_t;

    logic        clk_i = 1'b0;
    logic        reset_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        quad_a;
    logic        quad_b;
    logic        index_strobe;
    logic        irq;
    logic        calib_stop_motor;

    op_t         row_op   [48];
    logic [7:0]  row_addr [48];
    logic [31:0] row_data [48];
    logic [31:0] row_exp  [48];
    string       row_name [48];
    int          n_rows = 0;
    int          budget = 0;
    bit          run_started = 1'b0;
    integer      seed = 32'hc9d6150b;
    logic [1:0]  phase = 2'b00;
    logic [31:0] rd;
    logic [31:0] load_a;
    logic [31:0] base;
    logic [31:0] cal_load;
    int          n_up;
    int          n_dn;
    int          n_wrap;
    int          k;
    int          n_cal;
    int          m_cal;

    qenc_top dut0 (.*);

    always #2 clk_i = ~clk_i;

    ////////////////////////////////////////////////////////////
    // Checking and bus tasks
    ////////////////////////////////////////////////////////////

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("error %s: expected %h, actual %h", name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "check failed in %s", name);
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(negedge clk_i);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk_i);
        penable = 1'b1;
        @(negedge clk_i);
        while (!pready) @(negedge clk_i);
        rdata = prdata;
        err   = pslverr;
        // Hold the access through the edge that commits a write
        @(negedge clk_i);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input string name);
        logic [31:0] unused;
        logic        err;
        apb_xfer(1'b1, addr, data, unused, err);
        check(name, 32'd0, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic exp_err, input string name,
                            output logic [31:0] data);
        logic err;
        apb_xfer(1'b0, addr, 32'd0, data, err);
        check(name, exp_err, err);
    endtask

    // Gray sequence {b,a} = 00, 01, 11, 10 going up
    task automatic move_one(input bit up);
        @(negedge clk_i);
        phase = up ? phase + 2'd1 : phase - 2'd1;
        quad_b = phase[1];
        quad_a = phase[1] ^ phase[0];
        repeat (6) @(negedge clk_i);
    endtask

    task automatic pulse_index();
        @(negedge clk_i);
        index_strobe = 1'b1;
        repeat (2) @(negedge clk_i);
        index_strobe = 1'b0;
        repeat (6) @(negedge clk_i);
    endtask

    task automatic add_row(input op_t op, input logic [7:0] addr, input logic [31:0] data,
                           input logic [31:0] exp, input string name);
        row_op[n_rows]   = op;
        row_addr[n_rows] = addr;
        row_data[n_rows] = data;
        row_exp[n_rows]  = exp;
        row_name[n_rows] = name;
        n_rows = n_rows + 1;
        if (op == OP_UP || op == OP_DOWN) begin
            budget = budget + data + 1;
        end else if (op == OP_WAIT) begin
            budget = budget + 4;
        end else begin
            budget = budget + 1;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus table and run
    ////////////////////////////////////////////////////////////

    initial begin
        reset_n      = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = 8'h00;
        pwdata       = 32'd0;
        quad_a       = 1'b0;
        quad_b       = 1'b0;
        index_strobe = 1'b0;

        load_a   = $random(seed);
        n_up     = ($random(seed) & 15) + 3;
        n_dn     = ($random(seed) & 7) + 1;
        n_wrap   = ($random(seed) & 7) + 4;
        k        = ($random(seed) & 7) + 2;
        base     = $random(seed);
        cal_load = $random(seed);
        n_cal    = ($random(seed) & 7) + 2;
        m_cal    = ($random(seed) & 7) + 1;

        add_row(OP_READ, REG_COUNT, 0, 0, "reset_count");
        add_row(OP_READ, REG_THRESH, 0, 32'hffff_ffff, "reset_thresh");
        add_row(OP_READ, REG_STATUS, 0, 0, "reset_status");
        add_row(OP_PINS, 0, 0, 0, "reset_pins");
        add_row(OP_READ_ERR, 8'h18, 0, 0, "unmapped_read");
        add_row(OP_WRITE, REG_COUNT, load_a, 0, "load_random");
        add_row(OP_UP, 0, n_up, 0, "steps_up");
        add_row(OP_DOWN, 0, n_dn, 0, "steps_down");
        add_row(OP_READ, REG_COUNT, 0, load_a + n_up - n_dn, "count_up_down");
        add_row(OP_WRITE, REG_COUNT, 32'hffff_fffd, 0, "load_near_top");
        add_row(OP_UP, 0, n_wrap, 0, "steps_wrap");
        add_row(OP_READ, REG_COUNT, 0, 32'hffff_fffd + n_wrap, "count_wrap");
        // Count passed the all-ones reset threshold on the way round
        add_row(OP_READ, REG_STATUS, 0, 1, "wrap_status");
        add_row(OP_WRITE, REG_STATUS, 1, 0, "wrap_clear");
        add_row(OP_WRITE, REG_COUNT, base, 0, "thresh_base");
        add_row(OP_WRITE, REG_THRESH, base + k, 0, "thresh_set");
        add_row(OP_WRITE, REG_IRQ_EN, 1, 0, "irq_enable");
        add_row(OP_READ, REG_STATUS, 0, 0, "thresh_pending");
        add_row(OP_UP, 0, k, 0, "thresh_steps");
        add_row(OP_READ, REG_STATUS, 0, 1, "thresh_status");
        add_row(OP_PINS, 0, 0, 2, "thresh_irq");
        add_row(OP_WRITE, REG_STATUS, 1, 0, "thresh_clear");
        add_row(OP_READ, REG_STATUS, 0, 0, "thresh_cleared");
        add_row(OP_PINS, 0, 0, 0, "irq_dropped");
        add_row(OP_WRITE, REG_COUNT, cal_load, 0, "calib_load");
        add_row(OP_WRITE, REG_CTRL, 1, 0, "calib_start");
        add_row(OP_UP, 0, n_cal, 0, "calib_steps_before");
        add_row(OP_INDEX, 0, 0, 0, "calib_index");
        add_row(OP_PINS, 0, 0, 1, "calib_stop_req");
        add_row(OP_READ, REG_LATCHED, 0, cal_load + n_cal, "calib_latched");
        add_row(OP_WRITE, REG_CTRL, 1, 0, "calib_restart_ignored");
        add_row(OP_UP, 0, m_cal, 0, "calib_steps_after");
        add_row(OP_INDEX, 0, 0, 0, "calib_second_index");
        add_row(OP_READ, REG_LATCHED, 0, cal_load + n_cal, "latched_kept");
        add_row(OP_READ, REG_STATUS, 0, 4, "status_stop_req");
        add_row(OP_WRITE, REG_CTRL, 2, 0, "motor_stopped");
        add_row(OP_WAIT, REG_STATUS, 2, 0, "calib_wait_done");
        add_row(OP_READ, REG_COUNT, 0, m_cal, "calib_count");
        add_row(OP_PINS, 0, 0, 0, "calib_stop_released");
        add_row(OP_READ, REG_STATUS, 0, 2, "calib_status");
        add_row(OP_WRITE, REG_STATUS, 2, 0, "calib_clear");
        add_row(OP_READ, REG_STATUS, 0, 0, "calib_cleared");
        run_started = 1'b1;

        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        reset_n = 1'b0;

        for (int i = 0; i < n_rows; i++) begin
            case (row_op[i])
                OP_WRITE: apb_write(row_addr[i], row_data[i], row_name[i]);
                OP_READ: begin
                    apb_read(row_addr[i], 1'b0, row_name[i], rd);
                    check(row_name[i], row_exp[i], rd);
                end
                OP_READ_ERR: begin
                    apb_read(row_addr[i], 1'b1, row_name[i], rd);
                    check(row_name[i], row_exp[i], rd);
                end
                OP_UP:    repeat (row_data[i]) move_one(1'b1);
                OP_DOWN:  repeat (row_data[i]) move_one(1'b0);
                OP_INDEX: pulse_index();
                OP_WAIT: begin
                    rd = '0;
                    while ((rd & row_data[i]) == 0) apb_read(row_addr[i], 1'b0, row_name[i], rd);
                end
                OP_PINS: check(row_name[i], row_exp[i], {30'd0, irq, calib_stop_motor});
                default: check(row_name[i], 32'd0, 32'd1);
            endcase
        end

        $display("NO ERRORS");
        $finish;
    end

    // Watchdog scaled by the table
    initial begin
        wait (run_started);
        repeat (budget * 40) @(posedge clk_i);
        $display("Simulation timed out after %0d cycles", budget * 40);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    // A failed concurrent assertion in the register block ends the run
    initial begin
        wait (dut0.regs0.asserts0.fail_count != 0);
        $display("A concurrent assertion in the APB register block failed");
        $display("ERRORS FOUND");
        $fatal(1, "assertion failure");
    end

endmodule

// ==== dv/qenc_asserts.sv ====
`timescale 1ns/1ps

module qenc_asserts (
    input logic       clk_i,
    input logic       reset_n,
    input logic       pready,
    input logic       pslverr,
    input logic       irq,
    input logic [1:0] irq_en
);

    int fail_count = 0;

    ////////////////////////////////////////////////////////////
    // APB completion
    ////////////////////////////////////////////////////////////

    // Every transfer completes in a single pready cycle
    pready_single: assert property (
        @(posedge clk_i) disable iff (reset_n) pready |=> !pready
    ) else begin
        fail_count++;
        $error("pready stayed high for two consecutive cycles");
    end

    pslverr_with_pready: assert property (
        @(posedge clk_i) disable iff (reset_n) pslverr |-> pready
    ) else begin
        fail_count++;
        $error("pslverr raised without pready");
    end

    ////////////////////////////////////////////////////////////
    // Interrupt gating
    ////////////////////////////////////////////////////////////

    // irq is registered, so the mask one cycle back is what gates it
    irq_needs_enable: assert property (
        @(posedge clk_i) disable iff (reset_n) $rose(irq) |-> ($past(irq_en) != 2'b00)
    ) else begin
        fail_count++;
        $error("irq rose while every interrupt enable bit was clear");
    end

endmodule

bind qenc_apb_regs qenc_asserts asserts0 (
    .clk_i   (clk_i),
    .reset_n (reset_n),
    .pready  (pready),
    .pslverr (pslverr),
    .irq     (irq),
    .irq_en  (irq_en)
);

// ==== src/qenc_top.sv ====
`timescale 1ns/1ps

module qenc_top (
    input  logic        clk_i,
    input  logic        reset_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        quad_a,
    input  logic        quad_b,
    input  logic        index_strobe,
    output logic        irq,
    output logic        calib_stop_motor
);

    logic step;
    logic step_up;
    logic index_rise;

    qenc_ctrl_if ctrl_bus ();

    assign calib_stop_motor = ctrl_bus.calib_stop_motor;

    ////////////////////////////////////////////////////////////
    // Encoder front end and position core
    ////////////////////////////////////////////////////////////

    qenc_input_sync sync0 (
        .clk_i        (clk_i),
        .reset_n      (reset_n),
        .quad_a       (quad_a),
        .quad_b       (quad_b),
        .index_strobe (index_strobe),
        .step         (step),
        .step_up      (step_up),
        .index_rise   (index_rise)
    );

    qenc_position_core core0 (
        .clk_i      (clk_i),
        .reset_n    (reset_n),
        .step       (step),
        .step_up    (step_up),
        .index_rise (index_rise),
        .ctrl       (ctrl_bus.core)
    );

    // Software access
    qenc_apb_regs regs0 (
        .clk_i   (clk_i),
        .reset_n (reset_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .irq     (irq),
        .ctrl    (ctrl_bus.regs)
    );

endmodule

// ==== src/qenc_apb_regs.sv ====
`timescale 1ns/1ps

module qenc_apb_regs (
    input  logic        clk_i,
    input  logic        reset_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        irq,
    qenc_ctrl_if.regs ctrl
);
    import qenc_pkg::*;

    logic [COUNT_WIDTH-1:0] thresh_q;
    logic                   motor_stopped_q;
    logic [1:0]             status_sticky;
    logic [1:0]             irq_en;
    logic [1:0]             status_set;
    logic [1:0]             status_clr;
    logic [31:0]            rd_data;
    logic                   addr_hit;
    logic                   access;
    logic                   wr_commit;
    logic                   wr_ctrl;
    logic                   wr_count;
    logic                   wr_thresh;
    logic                   wr_status;
    logic                   wr_irq_en;

    ////////////////////////////////////////////////////////////
    // APB handshake
    ////////////////////////////////////////////////////////////

    assign access = psel & penable;

    // First access cycle is the wait state
    always_ff @(posedge clk_i) begin
        if (reset_n) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end else begin
            pready  <= access & ~pready;
            pslverr <= access & ~pready & ~addr_hit;
        end
    end

    always_ff @(posedge clk_i) begin
        if (access && !pready) begin
            prdata <= rd_data;
        end
    end

    // Decode and read mux with unmapped offsets reading as zero
    always_comb begin
        addr_hit = 1'b1;
        rd_data  = '0;
        case (paddr)
            REG_CTRL:    rd_data[CTRL_MOTOR_STOPPED_BIT] = motor_stopped_q;
            REG_COUNT:   rd_data = ctrl.count;
            REG_THRESH:  rd_data = thresh_q;
            REG_LATCHED: rd_data = ctrl.latched_count;
            REG_STATUS: begin
                rd_data[STAT_THRESH_BIT]     = status_sticky[STAT_THRESH_BIT];
                rd_data[STAT_CALIB_DONE_BIT] = status_sticky[STAT_CALIB_DONE_BIT];
                rd_data[STAT_STOP_REQ_BIT]   = ctrl.calib_stop_motor;
            end
            REG_IRQ_EN: begin
                rd_data[STAT_THRESH_BIT]     = irq_en[STAT_THRESH_BIT];
                rd_data[STAT_CALIB_DONE_BIT] = irq_en[STAT_CALIB_DONE_BIT];
            end
            default:     addr_hit = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Register writes
    ////////////////////////////////////////////////////////////

    // A write lands in the pready cycle and only if it was mapped
    assign wr_commit = access & pready & pwrite & ~pslverr;
    assign wr_ctrl   = wr_commit && (paddr == REG_CTRL);
    assign wr_count  = wr_commit && (paddr == REG_COUNT);
    assign wr_thresh = wr_commit && (paddr == REG_THRESH);
    assign wr_status = wr_commit && (paddr == REG_STATUS);
    assign wr_irq_en = wr_commit && (paddr == REG_IRQ_EN);

    assign ctrl.count_load       = wr_count;
    assign ctrl.count_load_value = pwdata;
    assign ctrl.calib_start      = wr_ctrl & pwdata[CTRL_CALIB_START_BIT];
    assign ctrl.thresh_value     = thresh_q;
    assign ctrl.motor_stopped    = motor_stopped_q;

    always_comb begin
        status_set = '0;
        status_clr = '0;
        status_set[STAT_THRESH_BIT]     = ctrl.thresh_hit;
        status_set[STAT_CALIB_DONE_BIT] = ctrl.calib_done;
        if (wr_status) begin
            status_clr[STAT_THRESH_BIT]     = pwdata[STAT_THRESH_BIT];
            status_clr[STAT_CALIB_DONE_BIT] = pwdata[STAT_CALIB_DONE_BIT];
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_n) begin
            thresh_q        <= THRESH_RESET;
            motor_stopped_q <= 1'b0;
            irq_en          <= '0;
            status_sticky   <= '0;
            irq             <= 1'b0;
        end else begin
            if (wr_thresh) begin
                thresh_q <= pwdata;
            end
            if (wr_ctrl) begin
                motor_stopped_q <= pwdata[CTRL_MOTOR_STOPPED_BIT];
            end
            if (wr_irq_en) begin
                irq_en[STAT_THRESH_BIT]     <= pwdata[STAT_THRESH_BIT];
                irq_en[STAT_CALIB_DONE_BIT] <= pwdata[STAT_CALIB_DONE_BIT];
            end
            // Set from hardware wins over a clear in the same cycle
            status_sticky <= (status_sticky & ~status_clr) | status_set;
            irq           <= |(status_sticky & irq_en);
        end
    end

endmodule

// ==== src/qenc_position_core.sv ====
`timescale 1ns/1ps

module qenc_position_core (
    input  logic clk_i,
    input  logic reset_n,
    input  logic step,
    input  logic step_up,
    input  logic index_rise,
    qenc_ctrl_if.core ctrl
);
    import qenc_pkg::*;

    calib_state_t           state_q;
    logic [COUNT_WIDTH-1:0] count_q;
    logic [COUNT_WIDTH-1:0] latched_q;
    logic [COUNT_WIDTH-1:0] calib_pos;
    logic                   stop_motor_q;
    logic                   thresh_eq;
    logic                   thresh_eq_q;

    assign ctrl.count            = count_q;
    assign ctrl.latched_count    = latched_q;
    assign ctrl.calib_stop_motor = stop_motor_q;

    ////////////////////////////////////////////////////////////
    // Position counter
    ////////////////////////////////////////////////////////////

    // Calibration rewrite beats a software load, which beats a step
    always_ff @(posedge clk_i) begin
        if (reset_n) begin
            count_q <= '0;
        end else if (state_q == CALIB_SET_POS) begin
            count_q <= calib_pos;
        end else if (ctrl.count_load) begin
            count_q <= ctrl.count_load_value;
        end else if (step) begin
            if (step_up) begin
                count_q <= count_q + 1'b1;
            end else begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Threshold event fires only on entry into equality
    assign thresh_eq       = (count_q == ctrl.thresh_value);
    assign ctrl.thresh_hit = thresh_eq & ~thresh_eq_q;

    always_ff @(posedge clk_i) begin
        if (reset_n) begin
            thresh_eq_q <= 1'b0;
        end else begin
            thresh_eq_q <= thresh_eq;
        end
    end

    ////////////////////////////////////////////////////////////
    // Calibration sequencer
    ////////////////////////////////////////////////////////////

    assign ctrl.calib_done = (state_q == CALIB_SET_POS);

    always_ff @(posedge clk_i) begin
        if (reset_n) begin
            state_q      <= CALIB_IDLE;
            latched_q    <= '0;
            stop_motor_q <= 1'b0;
        end else begin
            case (state_q)
                CALIB_IDLE: begin
                    if (ctrl.calib_start) begin
                        state_q <= CALIB_FIND_INDEX;
                    end
                end
                CALIB_FIND_INDEX: begin
                    if (index_rise) begin
                        latched_q    <= count_q;
                        stop_motor_q <= 1'b1;
                        state_q      <= CALIB_FIND_DIFF;
                    end
                end
                // Later index pulses are ignored here
                CALIB_FIND_DIFF: begin
                    if (ctrl.motor_stopped) begin
                        state_q <= CALIB_SET_POS;
                    end
                end
                CALIB_SET_POS: begin
                    stop_motor_q <= 1'b0;
                    state_q      <= CALIB_IDLE;
                end
                default: begin
                    state_q <= CALIB_IDLE;
                end
            endcase
        end
    end

    // Distance travelled since the index
    always_ff @(posedge clk_i) begin
        if (state_q == CALIB_FIND_DIFF && ctrl.motor_stopped) begin
            calib_pos <= count_q - latched_q;
        end
    end

endmodule

// ==== src/qenc_input_sync.sv ====
`timescale 1ns/1ps

module qenc_input_sync (
    input  logic clk_i,
    input  logic reset_n,
    input  logic quad_a,
    input  logic quad_b,
    input  logic index_strobe,
    output logic step,
    output logic step_up,
    output logic index_rise
);

    logic [2:0] pin_meta;
    logic [2:0] pin_sync;
    logic [2:0] pin_prev;
    logic       a_chg;
    logic       b_chg;

    // Bit order is {index, b, a}
    assign a_chg = pin_sync[0] ^ pin_prev[0];
    assign b_chg = pin_sync[1] ^ pin_prev[1];

    always_ff @(posedge clk_i) begin
        if (reset_n) begin
            pin_meta   <= '0;
            pin_sync   <= '0;
            pin_prev   <= '0;
            step       <= 1'b0;
            step_up    <= 1'b0;
            index_rise <= 1'b0;
        end else begin
            pin_meta <= {index_strobe, quad_b, quad_a};
            pin_sync <= pin_meta;
            pin_prev <= pin_sync;

            // A sample with both phases moved is dropped
            step <= a_chg ^ b_chg;
            if (a_chg) begin
                step_up <= pin_sync[0] ^ pin_sync[1];
            end else begin
                step_up <= ~(pin_sync[0] ^ pin_sync[1]);
            end

            index_rise <= pin_sync[2] & ~pin_prev[2];
        end
    end

endmodule

// ==== src/qenc_ctrl_if.sv ====
`timescale 1ns/1ps

interface qenc_ctrl_if;
    import qenc_pkg::*;

    // Software requests toward the core
    logic                   count_load;
    logic [COUNT_WIDTH-1:0] count_load_value;
    logic [COUNT_WIDTH-1:0] thresh_value;
    logic                   calib_start;
    logic                   motor_stopped;

    // Core state and events toward the registers
    logic [COUNT_WIDTH-1:0] count;
    logic [COUNT_WIDTH-1:0] latched_count;
    logic                   thresh_hit;
    logic                   calib_done;
    logic                   calib_stop_motor;

    modport regs (
        output count_load, count_load_value, thresh_value, calib_start, motor_stopped,
        input  count, latched_count, thresh_hit, calib_done, calib_stop_motor
    );

    modport core (
        input  count_load, count_load_value, thresh_value, calib_start, motor_stopped,
        output count, latched_count, thresh_hit, calib_done, calib_stop_motor
    );

endinterface

// ==== src/qenc_pkg.sv ====
package qenc_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and reset values
    ////////////////////////////////////////////////////////////

    localparam int COUNT_WIDTH = 32;

    // Threshold starts out of reach of a freshly reset count
    localparam logic [COUNT_WIDTH-1:0] THRESH_RESET = '1;

    ////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////

    localparam logic [7:0] REG_CTRL    = 8'h00;
    localparam logic [7:0] REG_COUNT   = 8'h04;
    localparam logic [7:0] REG_THRESH  = 8'h08;
    localparam logic [7:0] REG_LATCHED = 8'h0C;
    localparam logic [7:0] REG_STATUS  = 8'h10;
    localparam logic [7:0] REG_IRQ_EN  = 8'h14;

    // CTRL fields
    localparam int CTRL_CALIB_START_BIT   = 0;
    localparam int CTRL_MOTOR_STOPPED_BIT = 1;

    // STATUS and IRQ_EN fields
    localparam int STAT_THRESH_BIT     = 0;
    localparam int STAT_CALIB_DONE_BIT = 1;
    localparam int STAT_STOP_REQ_BIT   = 2;

    ////////////////////////////////////////////////////////////
    // Calibration sequencer
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        CALIB_IDLE       = 2'b00,
        CALIB_FIND_INDEX = 2'b01,
        CALIB_FIND_DIFF  = 2'b10,
        CALIB_SET_POS    = 2'b11
    } calib_state_t;

endpackage
